//--- project.f
logic/icache_pkg.sv
logic/cache_bus_pkg.sv
logic/plru_tree.sv
logic/tag_store.sv
logic/refill_counter.sv
logic/data_array.sv
logic/icache_ctrl.sv
logic/icache.sv
verification/icache_properties.sv
verification/icache_tb.sv

//--- Makefile
TOP = icache_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module icache
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q ">>> FAIL" sim.log; then exit 1; fi
	@if ! grep -q ">>> PASS" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- verification/icache_tb.sv
`default_nettype none

module icache_tb
    import icache_pkg::*;
    import cache_bus_pkg::*;
();

    localparam int NUM_STEPS = 20;
    localparam int WAIT_LIMIT = 300;

    typedef struct packed {
        logic [7:0]  test;
        logic [31:0] addr;
    } step_t;

    logic       clk;
    logic       resetn;
    ibus_req_t  ibus_req;
    ibus_resp_t ibus_resp;
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp;

    // cold misses, critical word, hits, one set replaced, early restart
    step_t steps [NUM_STEPS] = '{
        '{8'd2, 32'h0000_1008}, '{8'd2, 32'h0000_2034},
        '{8'd3, 32'h0000_300C},
        '{8'd4, 32'h0000_1008}, '{8'd4, 32'h0000_1000},
        '{8'd4, 32'h0000_1004}, '{8'd4, 32'h0000_100C},
        '{8'd5, 32'h0001_0010}, '{8'd5, 32'h0002_0010}, '{8'd5, 32'h0003_0010},
        '{8'd5, 32'h0004_0010}, '{8'd5, 32'h0005_0010},
        '{8'd5, 32'h0001_0010}, '{8'd5, 32'h0002_0010}, '{8'd5, 32'h0005_0010},
        '{8'd6, 32'h0006_0024}, '{8'd6, 32'h0006_0028}, '{8'd6, 32'h0006_0020},
        '{8'd6, 32'h0006_002C}, '{8'd6, 32'h0006_0024}
    };

    // reference copy of the tag state
    tag_t  ref_tag   [NUM_SETS][NUM_WAYS];
    logic  ref_valid [NUM_SETS][NUM_WAYS];
    plru_t ref_plru  [NUM_SETS];

    // memory model state
    logic [15:0] lfsr;
    logic        mem_busy;
    logic [31:0] mem_base;
    int          mem_beat;
    int          mem_gap;
    logic [3:0]  mem_landed;
    int          refill_count;
    offset_t     beat_off;

    int          errors;
    int          checks;
    logic        timed_out;

    icache UUT (
        .clk       (clk),
        .resetn    (resetn),
        .ibus_req  (ibus_req),
        .ibus_resp (ibus_resp),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] model_word(input logic [31:0] byte_addr);
        return {2'b00, byte_addr[31:2]} ^ 32'h5A5A_0000;
    endfunction

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic draw_gap(output int gap);
        logic [1:0] g;
        g = '0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_next(lfsr);
            g = {g[0], lfsr[0]};
        end
        gap = int'(g);
    endtask

    // left pair when bit 0 is low
    function automatic way_t pick_victim(input plru_t b);
        way_t v;
        if (!b[0]) begin
            v = b[1] ? way_t'(1) : way_t'(0);
        end else begin
            v = b[2] ? way_t'(3) : way_t'(2);
        end
        return v;
    endfunction

    function automatic plru_t point_away(input plru_t b, input way_t w);
        plru_t n;
        n = b;
        n[0] = (w < 2) ? 1'b1 : 1'b0;
        if (w < 2) begin
            n[1] = (w == 0) ? 1'b1 : 1'b0;
        end else begin
            n[2] = (w == 2) ? 1'b1 : 1'b0;
        end
        return n;
    endfunction

    // predicts hit or miss and updates tags and tree
    task automatic predict_access(input fetch_addr_t a, output logic miss);
        way_t w;
        miss = 1'b1;
        w = '0;
        for (int k = 0; k < NUM_WAYS; k++) begin
            if (ref_valid[a.index][k] && ref_tag[a.index][k] == a.tag) begin
                miss = 1'b0;
                w = way_t'(k);
            end
        end
        if (miss) begin
            w = pick_victim(ref_plru[a.index]);
            ref_tag[a.index][w] = a.tag;
            ref_valid[a.index][w] = 1'b1;
        end
        ref_plru[a.index] = point_away(ref_plru[a.index], w);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // memory side, beats driven on the falling edge
    always @(negedge clk) begin
        cbus_resp = '0;
        if (resetn) begin
            mem_busy = 1'b0;
            refill_count = 0;
        end else if (cbus_req.valid) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_base = cbus_req.addr;
                mem_beat = 0;
                mem_landed = '0;
                refill_count++;
                draw_gap(mem_gap);
            end
            assert (mem_beat < LINE_WORDS) else begin
                $display("cache bus valid still high after the last beat");
                errors++;
            end
            if (mem_beat < LINE_WORDS) begin
                if (mem_gap != 0) begin
                    mem_gap--;
                end else begin
                    beat_off = offset_t'(mem_base[3:2] + mem_beat);
                    cbus_resp.okay = 1'b1;
                    cbus_resp.last = (mem_beat == LINE_WORDS - 1);
                    cbus_resp.rdata = model_word({mem_base[31:4], beat_off, 2'b00});
                    mem_landed[beat_off] = 1'b1;
                    mem_beat++;
                    draw_gap(mem_gap);
                end
            end
        end else begin
            // a refill ends only after all four beats
            if (mem_busy) begin
                checks++;
                assert (mem_beat == LINE_WORDS) else begin
                    $display("cache bus valid dropped after %0d of %0d beats",
                             mem_beat, LINE_WORDS);
                    errors++;
                end
            end
            mem_busy = 1'b0;
        end
    end

    initial begin
        fetch_addr_t a;
        logic        pred_miss;
        logic        seen_miss;
        int          count_before;
        int          waited;

        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        lfsr = 16'd51394;
        resetn = 1'b1;
        ibus_req = '0;
        cbus_resp = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_plru[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w] = '0;
            end
        end

        // reset held for 4 cycles, then one quiet cycle
        for (int c = 0; c < 5; c++) begin
            @(negedge clk);
            if (c == 3) begin
                resetn = 1'b0;
            end
            check_value("addr_ok", ibus_resp.addr_ok, 1'b0);
            check_value("data_ok", ibus_resp.data_ok, 1'b0);
            check_value("cbus_req.valid", cbus_req.valid, 1'b0);
        end
        @(negedge clk);
        check_value("cbus_req.valid", cbus_req.valid, 1'b0);
        $display("test 1 done, %0d errors so far", errors);

        for (int i = 0; i < NUM_STEPS && !timed_out; i++) begin
            a = steps[i].addr;
            ibus_req.req = 1'b1;
            ibus_req.addr = steps[i].addr;
            count_before = refill_count;
            waited = 0;
            #1;
            while (!ibus_resp.addr_ok && waited < WAIT_LIMIT) begin
                @(negedge clk);
                #1;
                waited++;
            end
            if (waited >= WAIT_LIMIT) begin
                $display("timeout: addr_ok never rose for address %h", steps[i].addr);
                timed_out = 1'b1;
            end else begin
                // word of a line under refill must have arrived already
                if (cbus_req.valid && mem_base[31:4] == steps[i].addr[31:4]) begin
                    checks++;
                    assert (mem_landed[a.offset]) else begin
                        $display("word at %h accepted before its beat arrived",
                                 steps[i].addr);
                        errors++;
                    end
                end
                // hits are accepted in the cycle they are requested
                if (steps[i].test == 8'd4) begin
                    check_value("hit wait cycles", waited, 0);
                end
                predict_access(a, pred_miss);
                @(negedge clk);
                seen_miss = (refill_count != count_before);
                check_value("data_ok", ibus_resp.data_ok, 1'b1);
                check_value("data", ibus_resp.data, model_word(steps[i].addr));
                check_value("miss", seen_miss, pred_miss);
                if (seen_miss) begin
                    check_value("cbus_req.addr", mem_base, {steps[i].addr[31:2], 2'b00});
                end
                if (i == NUM_STEPS - 1) begin
                    ibus_req = '0;
                end
                if (i == NUM_STEPS - 1 || steps[i + 1].test != steps[i].test) begin
                    $display("test %0d done, %0d errors so far", steps[i].test, errors);
                end
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/icache_properties.sv
`default_nettype none

module icache_properties
    import cache_bus_pkg::*;
(
    input logic       clk,
    input logic       resetn,
    input ibus_req_t  ibus_req,
    input ibus_resp_t ibus_resp,
    input cbus_req_t  cbus_req,
    input cbus_resp_t cbus_resp
);

    // one data_ok per accepted request, exactly one cycle later
    a_data_ok_follows: assert property (@(posedge clk) disable iff (resetn)
        (ibus_req.req && ibus_resp.addr_ok) |=> ibus_resp.data_ok)
        else $error("data_ok missing after acceptance");

    a_no_spurious_data_ok: assert property (@(posedge clk) disable iff (resetn)
        !(ibus_req.req && ibus_resp.addr_ok) |=> !ibus_resp.data_ok)
        else $error("data_ok without acceptance");

    // request held until the last beat
    a_cbus_stable: assert property (@(posedge clk) disable iff (resetn)
        (cbus_req.valid && !(cbus_resp.okay && cbus_resp.last))
        |=> (cbus_req.valid && $stable(cbus_req.addr)))
        else $error("cache bus request changed before last");

    a_reset_quiet: assert property (@(posedge clk)
        $past(resetn) |->
        (!ibus_resp.addr_ok && !ibus_resp.data_ok && !cbus_req.valid))
        else $error("outputs active during reset");

endmodule

bind icache icache_properties u_properties (
    .clk       (clk),
    .resetn    (resetn),
    .ibus_req  (ibus_req),
    .ibus_resp (ibus_resp),
    .cbus_req  (cbus_req),
    .cbus_resp (cbus_resp)
);

`default_nettype wire

//--- logic/icache.sv
`default_nettype none

module icache
    import icache_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  ibus_req_t  ibus_req,
    output ibus_resp_t ibus_resp,
    output cbus_req_t  cbus_req,
    input  cbus_resp_t cbus_resp
);

    fetch_addr_t           req_addr;
    logic                  hit;
    way_t                  hit_way;
    way_t                  victim;
    logic                  accept;
    logic                  refill_start;
    way_t                  refill_way;
    index_t                refill_index;
    way_t                  read_way;
    logic                  addr_ok;
    logic                  data_ok;
    offset_t               write_offset;
    logic                  write_en;
    logic [LINE_WORDS-1:0] landed;
    word_t                 rdata;

    assign req_addr = ibus_req.addr;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .ibus_req     (ibus_req),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim       (victim),
        .landed       (landed),
        .cbus_resp    (cbus_resp),
        .accept       (accept),
        .refill_start (refill_start),
        .refill_way   (refill_way),
        .refill_index (refill_index),
        .read_way     (read_way),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .cbus_req     (cbus_req)
    );

    refill_counter u_refill_counter (
        .clk          (clk),
        .resetn       (resetn),
        .refill_start (refill_start),
        .start_offset (req_addr.offset),
        .okay         (cbus_resp.okay),
        .write_offset (write_offset),
        .write_en     (write_en),
        .landed       (landed)
    );

    tag_store u_tag_store (
        .clk       (clk),
        .resetn    (resetn),
        .index     (req_addr.index),
        .tag       (req_addr.tag),
        .touch     (accept),
        .touch_way (hit_way),
        .fill      (refill_start),
        .fill_way  (refill_way),
        .hit       (hit),
        .hit_way   (hit_way),
        .victim    (victim)
    );

    data_array u_data_array (
        .clk          (clk),
        .read_way     (read_way),
        .read_index   (req_addr.index),
        .read_offset  (req_addr.offset),
        .write_en     (write_en),
        .write_way    (refill_way),
        .write_index  (refill_index),
        .write_offset (write_offset),
        .wdata        (cbus_resp.rdata),
        .rdata        (rdata)
    );

    assign ibus_resp.addr_ok = addr_ok;
    assign ibus_resp.data_ok = data_ok;
    assign ibus_resp.data    = rdata;

endmodule

`default_nettype wire

//--- logic/icache_ctrl.sv
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  ibus_req_t             ibus_req,
    input  logic                  hit,
    input  way_t                  hit_way,
    input  way_t                  victim,
    input  logic [LINE_WORDS-1:0] landed,
    input  cbus_resp_t            cbus_resp,
    output logic                  accept,
    output logic                  refill_start,
    output way_t                  refill_way,
    output index_t                refill_index,
    output way_t                  read_way,
    output logic                  addr_ok,
    output logic                  data_ok,
    output cbus_req_t             cbus_req
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    fetch_addr_t req_addr;
    fetch_addr_t miss_addr;
    way_t        miss_way;
    logic        in_refill;
    logic        word_ready;

    assign req_addr = ibus_req.addr;

    // same line as the one being refilled
    assign in_refill = (state == REFILL) &&
        (hit_way == miss_way) && (req_addr.index == miss_addr.index);

    // early restart: word usable once its beat has been written
    assign word_ready = hit && (!in_refill || landed[req_addr.offset]);

    assign addr_ok = ibus_req.req && word_ready;
    assign accept  = addr_ok;

    // new misses only from IDLE, others wait with addr_ok low
    assign refill_start = ibus_req.req && !hit && (state == IDLE);

    // victim feeds the tag fill, captured way feeds the data writes
    assign refill_way   = (state == IDLE) ? victim : miss_way;
    assign refill_index = miss_addr.index;
    assign read_way     = hit_way;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (refill_start) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (cbus_resp.okay && cbus_resp.last) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state   <= IDLE;
            data_ok <= 1'b0;
        end else begin
            state   <= state_next;
            data_ok <= accept;
        end
    end

    // missed word address, byte bits forced to zero
    always_ff @(posedge clk) begin
        if (refill_start) begin
            miss_addr.tag    <= req_addr.tag;
            miss_addr.index  <= req_addr.index;
            miss_addr.offset <= req_addr.offset;
            miss_addr.align  <= '0;
            miss_way         <= victim;
        end
    end

    assign cbus_req.valid = (state == REFILL);
    assign cbus_req.addr  = miss_addr;

endmodule

`default_nettype wire

//--- logic/data_array.sv
`default_nettype none

module data_array
    import icache_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic    clk,
    input  way_t    read_way,
    input  index_t  read_index,
    input  offset_t read_offset,
    input  logic    write_en,
    input  way_t    write_way,
    input  index_t  write_index,
    input  offset_t write_offset,
    input  word_t   wdata,
    output word_t   rdata
);

    // one word per way, set and offset
    word_t mem [NUM_WAYS * NUM_SETS * LINE_WORDS];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[{write_way, write_index, write_offset}] <= wdata;
        end
    end

    // registered read, old word on a same-cycle collision
    always_ff @(posedge clk) begin
        rdata <= mem[{read_way, read_index, read_offset}];
    end

endmodule

`default_nettype wire

//--- logic/refill_counter.sv
`default_nettype none

module refill_counter
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  refill_start,
    input  offset_t               start_offset,
    input  logic                  okay,
    output offset_t               write_offset,
    output logic                  write_en,
    output logic [LINE_WORDS-1:0] landed
);

    offset_t               offset_q;
    logic [LINE_WORDS-1:0] landed_q;
    logic [LINE_WORDS-1:0] beat_mask;

    // bit of the word arriving on this beat
    always_comb begin
        beat_mask = '0;
        beat_mask[offset_q] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            offset_q <= '0;
            landed_q <= '0;
        end else if (refill_start) begin
            // critical word goes first
            offset_q <= start_offset;
            landed_q <= '0;
        end else if (okay) begin
            // wraps inside the line
            offset_q <= offset_q + 1'b1;
            landed_q <= landed_q | beat_mask;
        end
    end

    assign write_offset = offset_q;
    assign write_en     = okay;
    assign landed       = landed_q;

endmodule

`default_nettype wire

//--- logic/tag_store.sv
`default_nettype none

module tag_store
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  index_t index,
    input  tag_t   tag,
    input  logic   touch,
    input  way_t   touch_way,
    input  logic   fill,
    input  way_t   fill_way,
    output logic   hit,
    output way_t   hit_way,
    output way_t   victim
);

    tag_t                tags  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    plru_t               plru  [NUM_SETS];

    logic [NUM_WAYS-1:0] match;
    way_t                touched;
    plru_t               new_bits;

    // compare against every way of the set
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_match
        assign match[w] = valid[index][w] && (tags[index][w] == tag);
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |match;

    // a fill and a touch never happen in the same cycle
    assign touched = fill ? fill_way : touch_way;

    plru_tree u_plru (
        .bits     (plru[index]),
        .touched  (touched),
        .victim   (victim),
        .new_bits (new_bits)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                plru[s]  <= '0;
            end
        end else if (fill) begin
            valid[index][fill_way] <= 1'b1;
            plru[index]            <= new_bits;
        end else if (touch) begin
            plru[index] <= new_bits;
        end
    end

    // new tag written as soon as the miss is claimed
    always_ff @(posedge clk) begin
        if (fill) begin
            tags[index][fill_way] <= tag;
        end
    end

endmodule

`default_nettype wire

//--- logic/plru_tree.sv
`default_nettype none

module plru_tree
    import icache_pkg::*;
(
    input  plru_t bits,
    input  way_t  touched,
    output way_t  victim,
    output plru_t new_bits
);

    // bit 0 picks the pair, 0 means ways 0/1
    // bit 1 splits ways 0/1, bit 2 splits ways 2/3
    always_comb begin
        if (bits[0]) begin
            victim = {1'b1, bits[2]};
        end else begin
            victim = {1'b0, bits[1]};
        end
    end

    // point every node on the path away from the touched way
    always_comb begin
        new_bits    = bits;
        new_bits[0] = ~touched[1];
        if (touched[1]) begin
            new_bits[2] = ~touched[0];
        end else begin
            new_bits[1] = ~touched[0];
        end
    end

endmodule

`default_nettype wire

//--- logic/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

    localparam int WORD_BITS = 32;
    localparam int ADDR_BITS = 32;

    typedef logic [WORD_BITS-1:0] word_t;

    // fetch side, req held until addr_ok
    typedef struct packed {
        logic                 req;
        logic [ADDR_BITS-1:0] addr;
    } ibus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } ibus_resp_t;

    // memory side, one word per okay beat
    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] addr;
    } cbus_req_t;

    typedef struct packed {
        logic  okay;
        logic  last;
        word_t rdata;
    } cbus_resp_t;

endpackage

`default_nettype wire

//--- logic/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 4;
    localparam int LINE_WORDS = 4;

    // byte address split, high to low: tag, index, offset, align
    localparam int TAG_BITS    = 26;
    localparam int INDEX_BITS  = 2;
    localparam int OFFSET_BITS = 2;
    localparam int ALIGN_BITS  = 2;

    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;
    typedef logic [INDEX_BITS-1:0]       index_t;
    typedef logic [OFFSET_BITS-1:0]      offset_t;
    typedef logic [TAG_BITS-1:0]         tag_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] align;
    } fetch_addr_t;

    // one bit per inner node of the replacement tree
    typedef logic [NUM_WAYS-2:0] plru_t;

    typedef enum logic {
        IDLE,
        REFILL
    } ctrl_state_t;

endpackage

`default_nettype wire
